// ==== src/lc4_isa_pkg.sv ====
// LC4 instruction set: widths, opcodes, sub-op codes, field positions,
// the NZP type, the decoded control bundle and the NZP helper
package lc4_isa_pkg;

    localparam int XLEN = 16;

    typedef logic [XLEN-1:0] insn_t;
    typedef logic [2:0]      reg_sel_t;
    // negative, zero, positive
    typedef logic [2:0]      nzp_t;

    localparam logic [3:0] OP_BR    = 4'b0000;
    localparam logic [3:0] OP_ARITH = 4'b0001;
    localparam logic [3:0] OP_LOGIC = 4'b0101;
    localparam logic [3:0] OP_LDR   = 4'b0110;
    localparam logic [3:0] OP_STR   = 4'b0111;
    localparam logic [3:0] OP_CONST = 4'b1001;

    // insn[5:3] of register forms, insn[5] set means the imm5 form
    localparam logic [2:0] ARITH_ADD = 3'b000;
    localparam logic [2:0] ARITH_MUL = 3'b001;
    localparam logic [2:0] ARITH_SUB = 3'b010;
    localparam logic [2:0] ARITH_DIV = 3'b011;
    localparam logic [2:0] LOGIC_AND = 3'b000;
    localparam logic [2:0] LOGIC_NOT = 3'b001;
    localparam logic [2:0] LOGIC_OR  = 3'b010;

    // low bit of each instruction field
    localparam int OPC_LSB = 12;
    localparam int RD_LSB  = 9;
    localparam int RS_LSB  = 6;
    localparam int SUB_LSB = 3;
    localparam int RT_LSB  = 0;

    typedef struct packed {
        reg_sel_t rs_sel;
        reg_sel_t rt_sel;
        reg_sel_t rd_sel;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
    } decoded_t;

    function automatic nzp_t nzp_of(input logic [XLEN-1:0] value);
        if (value == '0) begin
            return 3'b010;
        end
        return value[XLEN-1] ? 3'b100 : 3'b001;
    endfunction

endpackage

// ==== src/lc4_pipe_pkg.sv ====
// pipeline definitions: stall codes and the structs crossing each
// stage boundary, the last one doubling as the writeback trace
package lc4_pipe_pkg;

    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_FLUSH = 2'd2,
        STALL_LOAD  = 2'd3
    } stall_t;

    typedef struct packed {
        logic [lc4_isa_pkg::XLEN-1:0] pc;
        lc4_isa_pkg::insn_t           insn;
        stall_t                       stall;
    } fd_t;

    typedef struct packed {
        logic [lc4_isa_pkg::XLEN-1:0] pc;
        lc4_isa_pkg::insn_t           insn;
        lc4_isa_pkg::decoded_t        dec;
        logic [lc4_isa_pkg::XLEN-1:0] rs_val;
        logic [lc4_isa_pkg::XLEN-1:0] rt_val;
        stall_t                       stall;
    } dx_t;

    typedef struct packed {
        logic [lc4_isa_pkg::XLEN-1:0] pc;
        lc4_isa_pkg::insn_t           insn;
        lc4_isa_pkg::decoded_t        dec;
        logic [lc4_isa_pkg::XLEN-1:0] result;
        logic [lc4_isa_pkg::XLEN-1:0] st_data;
        lc4_isa_pkg::nzp_t            nzp;
        stall_t                       stall;
    } xm_t;

    // register write bundle and retirement trace in one
    typedef struct packed {
        logic [lc4_isa_pkg::XLEN-1:0] pc;
        lc4_isa_pkg::insn_t           insn;
        stall_t                       stall;
        logic                         rd_we;
        lc4_isa_pkg::reg_sel_t        rd;
        logic [lc4_isa_pkg::XLEN-1:0] wdata;
        logic                         nzp_we;
        lc4_isa_pkg::nzp_t            nzp;
        logic                         dmem_we;
        logic [lc4_isa_pkg::XLEN-1:0] dmem_addr;
        logic [lc4_isa_pkg::XLEN-1:0] dmem_data;
    } wb_t;

endpackage

// ==== src/lc4_fetch_stage.sv ====
// fetch stage: program counter, next-PC selection and the F/D register
`timescale 1ns/1ps

module lc4_fetch_stage #(
    parameter logic [15:0] RESET_PC = 16'h8200
) (
    input  logic               gwe,
    input  logic               i_rst,
    input  logic               i_stall,
    input  logic               i_redirect,
    input  logic [15:0]        i_target,
    output logic [15:0]        o_imem_addr,
    input  lc4_isa_pkg::insn_t i_imem_insn,
    output lc4_pipe_pkg::fd_t  o_fd
);

    logic [15:0] pc;
    logic [15:0] next_pc;

    assign o_imem_addr = pc;

    // predict not taken, a taken branch in X overrides a hazard hold
    always_comb begin
        if (i_redirect) begin
            next_pc = i_target;
        end else if (i_stall) begin
            next_pc = pc;
        end else begin
            next_pc = pc + 16'd1;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst || i_redirect) begin
            o_fd <= '{stall: lc4_pipe_pkg::STALL_FLUSH, default: '0};
        end else if (!i_stall) begin
            o_fd <= '{pc: pc, insn: i_imem_insn, stall: lc4_pipe_pkg::STALL_NONE};
        end
    end

endmodule

// ==== src/lc4_decode_stage.sv ====
// decode stage: instruction decoder, register file with W write-through,
// load hazard detection and the D/X register
`timescale 1ns/1ps

module lc4_decode_stage (
    input  logic                  gwe,
    input  logic                  i_rst,
    input  lc4_pipe_pkg::fd_t     i_fd,
    input  logic                  i_x_load,
    input  lc4_isa_pkg::reg_sel_t i_x_rd,
    input  logic                  i_redirect,
    input  lc4_pipe_pkg::wb_t     i_wb,
    output logic                  o_stall,
    output lc4_pipe_pkg::dx_t     o_dx
);

    lc4_isa_pkg::decoded_t dec;
    logic [3:0]            opcode;
    logic [2:0]            sub_op;
    logic [15:0]           regs [8];
    logic [15:0]           rs_val;
    logic [15:0]           rt_val;

    assign opcode = i_fd.insn[lc4_isa_pkg::OPC_LSB +: 4];
    assign sub_op = i_fd.insn[lc4_isa_pkg::SUB_LSB +: 3];

    // bubbles and opcodes outside the subset decode to a NOP
    always_comb begin
        dec = '0;
        if (i_fd.stall == lc4_pipe_pkg::STALL_NONE) begin
            case (opcode)
                lc4_isa_pkg::OP_BR: begin
                    dec.is_branch = 1'b1;
                end
                lc4_isa_pkg::OP_ARITH, lc4_isa_pkg::OP_LOGIC: begin
                    if (opcode == lc4_isa_pkg::OP_LOGIC || sub_op != lc4_isa_pkg::ARITH_DIV) begin
                        dec.rs_sel = i_fd.insn[lc4_isa_pkg::RS_LSB +: 3];
                        dec.rd_sel = i_fd.insn[lc4_isa_pkg::RD_LSB +: 3];
                        dec.rs_re  = 1'b1;
                        dec.rd_we  = 1'b1;
                        dec.nzp_we = 1'b1;
                        // immediate forms and NOT have no second source
                        if (!sub_op[2] && !(opcode == lc4_isa_pkg::OP_LOGIC
                                && sub_op == lc4_isa_pkg::LOGIC_NOT)) begin
                            dec.rt_sel = i_fd.insn[lc4_isa_pkg::RT_LSB +: 3];
                            dec.rt_re  = 1'b1;
                        end
                    end
                end
                lc4_isa_pkg::OP_LDR: begin
                    dec.rs_sel  = i_fd.insn[lc4_isa_pkg::RS_LSB +: 3];
                    dec.rd_sel  = i_fd.insn[lc4_isa_pkg::RD_LSB +: 3];
                    dec.rs_re   = 1'b1;
                    dec.rd_we   = 1'b1;
                    dec.nzp_we  = 1'b1;
                    dec.is_load = 1'b1;
                end
                lc4_isa_pkg::OP_STR: begin
                    // store data register sits in the rd field
                    dec.rs_sel   = i_fd.insn[lc4_isa_pkg::RS_LSB +: 3];
                    dec.rt_sel   = i_fd.insn[lc4_isa_pkg::RD_LSB +: 3];
                    dec.rs_re    = 1'b1;
                    dec.rt_re    = 1'b1;
                    dec.is_store = 1'b1;
                end
                lc4_isa_pkg::OP_CONST: begin
                    dec.rd_sel = i_fd.insn[lc4_isa_pkg::RD_LSB +: 3];
                    dec.rd_we  = 1'b1;
                    dec.nzp_we = 1'b1;
                end
                default: begin
                    dec = '0;
                end
            endcase
        end
    end

    // the value being written this cycle is visible to the read
    always_comb begin
        rs_val = regs[dec.rs_sel];
        rt_val = regs[dec.rt_sel];
        if (i_wb.rd_we && i_wb.rd == dec.rs_sel) begin
            rs_val = i_wb.wdata;
        end
        if (i_wb.rd_we && i_wb.rd == dec.rt_sel) begin
            rt_val = i_wb.wdata;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.rd_we) begin
            regs[i_wb.rd] <= i_wb.wdata;
        end
    end

    // store data is excluded, WM bypass delivers it in time
    assign o_stall = i_x_load && (dec.is_branch
                     || (dec.rs_re && dec.rs_sel == i_x_rd)
                     || (dec.rt_re && !dec.is_store && dec.rt_sel == i_x_rd));

    always_ff @(posedge gwe) begin
        if (i_rst || i_redirect) begin
            o_dx <= '{stall: lc4_pipe_pkg::STALL_FLUSH, default: '0};
        end else if (o_stall) begin
            o_dx <= '{stall: lc4_pipe_pkg::STALL_LOAD, default: '0};
        end else begin
            o_dx <= '{pc: i_fd.pc, insn: i_fd.insn, dec: dec, rs_val: rs_val,
                      rt_val: rt_val, stall: i_fd.stall};
        end
    end

endmodule

// ==== src/lc4_execute_stage.sv ====
// execute stage: MX/WX operand bypass, ALU, NZP register,
// branch resolution and the X/M register
`timescale 1ns/1ps

module lc4_execute_stage (
    input  logic                  gwe,
    input  logic                  i_rst,
    input  lc4_pipe_pkg::dx_t     i_dx,
    input  lc4_pipe_pkg::wb_t     i_wb,
    input  lc4_isa_pkg::nzp_t     i_load_nzp,
    output logic                  o_redirect,
    output logic [15:0]           o_target,
    output logic                  o_x_load,
    output lc4_isa_pkg::reg_sel_t o_x_rd,
    output lc4_pipe_pkg::xm_t     o_xm
);

    logic [3:0]        opcode;
    logic [2:0]        sub_op;
    logic [15:0]       imm5;
    logic [15:0]       imm6;
    logic [15:0]       imm9;
    logic [15:0]       rs_op;
    logic [15:0]       rt_op;
    logic [15:0]       result;
    lc4_isa_pkg::nzp_t nzp_q;

    assign opcode = i_dx.insn[lc4_isa_pkg::OPC_LSB +: 4];
    assign sub_op = i_dx.insn[lc4_isa_pkg::SUB_LSB +: 3];
    assign imm5   = {{11{i_dx.insn[4]}}, i_dx.insn[4:0]};
    assign imm6   = {{10{i_dx.insn[5]}}, i_dx.insn[5:0]};
    assign imm9   = {{7{i_dx.insn[8]}}, i_dx.insn[8:0]};

    // MX over WX over the register read
    // a load in M has no data yet and the load-use stall keeps its users out
    always_comb begin
        rs_op = i_dx.rs_val;
        rt_op = i_dx.rt_val;
        if (i_wb.rd_we && i_wb.rd == i_dx.dec.rs_sel) begin
            rs_op = i_wb.wdata;
        end
        if (i_wb.rd_we && i_wb.rd == i_dx.dec.rt_sel) begin
            rt_op = i_wb.wdata;
        end
        if (o_xm.dec.rd_we && !o_xm.dec.is_load && o_xm.dec.rd_sel == i_dx.dec.rs_sel) begin
            rs_op = o_xm.result;
        end
        if (o_xm.dec.rd_we && !o_xm.dec.is_load && o_xm.dec.rd_sel == i_dx.dec.rt_sel) begin
            rt_op = o_xm.result;
        end
    end

    always_comb begin
        result = '0;
        case (opcode)
            lc4_isa_pkg::OP_BR: begin
                result = i_dx.pc + 16'd1 + imm9;
            end
            lc4_isa_pkg::OP_ARITH: begin
                if (sub_op[2]) begin
                    result = rs_op + imm5;
                end else if (sub_op == lc4_isa_pkg::ARITH_MUL) begin
                    result = rs_op * rt_op;
                end else if (sub_op == lc4_isa_pkg::ARITH_SUB) begin
                    result = rs_op - rt_op;
                end else begin
                    result = rs_op + rt_op;
                end
            end
            lc4_isa_pkg::OP_LOGIC: begin
                if (sub_op[2]) begin
                    result = rs_op & imm5;
                end else if (sub_op == lc4_isa_pkg::LOGIC_AND) begin
                    result = rs_op & rt_op;
                end else if (sub_op == lc4_isa_pkg::LOGIC_NOT) begin
                    result = ~rs_op;
                end else if (sub_op == lc4_isa_pkg::LOGIC_OR) begin
                    result = rs_op | rt_op;
                end else begin
                    result = rs_op ^ rt_op;
                end
            end
            lc4_isa_pkg::OP_LDR, lc4_isa_pkg::OP_STR: begin
                result = rs_op + imm6;
            end
            lc4_isa_pkg::OP_CONST: begin
                result = imm9;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // the load-branch stall keeps a load out of M while a branch is in X
    assign o_redirect = i_dx.dec.is_branch && |(nzp_q & i_dx.insn[11:9]);
    assign o_target   = result;
    assign o_x_load   = i_dx.dec.is_load;
    assign o_x_rd     = i_dx.dec.rd_sel;

    // ALU ops set flags from X, loads from M, the younger X op wins
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            nzp_q <= '0;
        end else if (i_dx.dec.nzp_we && !i_dx.dec.is_load) begin
            nzp_q <= lc4_isa_pkg::nzp_of(result);
        end else if (o_xm.dec.is_load) begin
            nzp_q <= i_load_nzp;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            o_xm <= '{stall: lc4_pipe_pkg::STALL_FLUSH, default: '0};
        end else begin
            o_xm <= '{pc: i_dx.pc, insn: i_dx.insn, dec: i_dx.dec, result: result,
                      st_data: rt_op, nzp: lc4_isa_pkg::nzp_of(result), stall: i_dx.stall};
        end
    end

endmodule

// ==== src/lc4_memory_stage.sv ====
// memory stage: data memory ports with WM store-data bypass,
// load flags, writeback value selection and the M/W register
`timescale 1ns/1ps

module lc4_memory_stage (
    input  logic              gwe,
    input  logic              i_rst,
    input  lc4_pipe_pkg::xm_t i_xm,
    input  logic [15:0]       i_dmem_rdata,
    output logic [15:0]       o_dmem_addr,
    output logic              o_dmem_we,
    output logic [15:0]       o_dmem_wdata,
    output lc4_isa_pkg::nzp_t o_load_nzp,
    output lc4_pipe_pkg::wb_t o_wb
);

    logic              mem_op;
    logic [15:0]       st_data;
    lc4_pipe_pkg::wb_t wb_next;

    assign mem_op = i_xm.dec.is_load || i_xm.dec.is_store;

    // WM bypass, mainly for a store right behind a load of its data register
    assign st_data = (o_wb.rd_we && o_wb.rd == i_xm.dec.rt_sel) ? o_wb.wdata : i_xm.st_data;

    assign o_dmem_addr  = mem_op ? i_xm.result : '0;
    assign o_dmem_we    = i_xm.dec.is_store;
    assign o_dmem_wdata = st_data;
    assign o_load_nzp   = lc4_isa_pkg::nzp_of(i_dmem_rdata);

    // fields an instruction does not use stay zero on the trace
    always_comb begin
        wb_next           = '{pc: i_xm.pc, insn: i_xm.insn, stall: i_xm.stall, default: '0};
        wb_next.rd_we     = i_xm.dec.rd_we;
        wb_next.rd        = i_xm.dec.rd_sel;
        wb_next.nzp_we    = i_xm.dec.nzp_we;
        wb_next.dmem_we   = i_xm.dec.is_store;
        wb_next.dmem_addr = o_dmem_addr;
        if (i_xm.dec.is_load) begin
            wb_next.wdata     = i_dmem_rdata;
            wb_next.nzp       = o_load_nzp;
            wb_next.dmem_data = i_dmem_rdata;
        end else begin
            wb_next.wdata = i_xm.dec.rd_we ? i_xm.result : '0;
            wb_next.nzp   = i_xm.dec.nzp_we ? i_xm.nzp : '0;
        end
        if (i_xm.dec.is_store) begin
            wb_next.dmem_data = st_data;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            o_wb <= '{stall: lc4_pipe_pkg::STALL_FLUSH, default: '0};
        end else begin
            o_wb <= wb_next;
        end
    end

endmodule

// ==== src/lc4_core.sv ====
// LC4 five-stage pipeline top level joining fetch, decode,
// execute and memory, with the memory ports and writeback trace
`timescale 1ns/1ps

module lc4_core #(
    parameter logic [15:0] RESET_PC = 16'h8200
) (
    input  logic               gwe,
    input  logic               i_rst,
    output logic [15:0]        o_imem_addr,
    input  lc4_isa_pkg::insn_t i_imem_insn,
    output logic [15:0]        o_dmem_addr,
    output logic               o_dmem_we,
    output logic [15:0]        o_dmem_wdata,
    input  logic [15:0]        i_dmem_rdata,
    output lc4_pipe_pkg::wb_t  o_wb
);

    lc4_pipe_pkg::fd_t     fd;
    lc4_pipe_pkg::dx_t     dx;
    lc4_pipe_pkg::xm_t     xm;
    logic                  stall;
    logic                  redirect;
    logic [15:0]           target;
    logic                  x_load;
    lc4_isa_pkg::reg_sel_t x_rd;
    lc4_isa_pkg::nzp_t     load_nzp;

    lc4_fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .gwe        (gwe),
        .i_rst      (i_rst),
        .i_stall    (stall),
        .i_redirect (redirect),
        .i_target   (target),
        .o_imem_addr(o_imem_addr),
        .i_imem_insn(i_imem_insn),
        .o_fd       (fd)
    );

    lc4_decode_stage u_decode (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_fd      (fd),
        .i_x_load  (x_load),
        .i_x_rd    (x_rd),
        .i_redirect(redirect),
        .i_wb      (o_wb),
        .o_stall   (stall),
        .o_dx      (dx)
    );

    lc4_execute_stage u_execute (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_dx      (dx),
        .i_wb      (o_wb),
        .i_load_nzp(load_nzp),
        .o_redirect(redirect),
        .o_target  (target),
        .o_x_load  (x_load),
        .o_x_rd    (x_rd),
        .o_xm      (xm)
    );

    lc4_memory_stage u_memory (
        .gwe         (gwe),
        .i_rst       (i_rst),
        .i_xm        (xm),
        .i_dmem_rdata(i_dmem_rdata),
        .o_dmem_addr (o_dmem_addr),
        .o_dmem_we   (o_dmem_we),
        .o_dmem_wdata(o_dmem_wdata),
        .o_load_nzp  (load_nzp),
        .o_wb        (o_wb)
    );

endmodule

// ==== include/lc4_tb_ref.svh ====
// instruction encoders for the kept LC4 subset and a reference model
// that executes one instruction and returns its expected trace record
`ifndef LC4_TB_REF_SVH
`define LC4_TB_REF_SVH

function automatic lc4_isa_pkg::insn_t enc_rrr(input logic [3:0] op, input logic [2:0] sub,
        input lc4_isa_pkg::reg_sel_t rd, input lc4_isa_pkg::reg_sel_t rs,
        input lc4_isa_pkg::reg_sel_t rt);
    return {op, rd, rs, sub, rt};
endfunction

function automatic lc4_isa_pkg::insn_t enc_imm5(input logic [3:0] op,
        input lc4_isa_pkg::reg_sel_t rd, input lc4_isa_pkg::reg_sel_t rs,
        input logic [4:0] imm5);
    return {op, rd, rs, 1'b1, imm5};
endfunction

// LDR and STR, r is the destination or the store data register
function automatic lc4_isa_pkg::insn_t enc_mem(input logic [3:0] op,
        input lc4_isa_pkg::reg_sel_t r, input lc4_isa_pkg::reg_sel_t rs,
        input logic [5:0] imm6);
    return {op, r, rs, imm6};
endfunction

function automatic lc4_isa_pkg::insn_t enc_const(input lc4_isa_pkg::reg_sel_t rd,
        input logic [8:0] imm9);
    return {lc4_isa_pkg::OP_CONST, rd, imm9};
endfunction

function automatic lc4_isa_pkg::insn_t enc_br(input lc4_isa_pkg::nzp_t nzp,
        input logic [8:0] imm9);
    return {lc4_isa_pkg::OP_BR, nzp, imm9};
endfunction

// updates pc, registers, flags and data memory in place
// data memory is indexed by the low eight address bits
function automatic lc4_pipe_pkg::wb_t ref_step(input lc4_isa_pkg::insn_t insn,
        ref logic [15:0] pc, ref logic [15:0] regs [8], ref lc4_isa_pkg::nzp_t nzp,
        ref logic [15:0] dmem [256]);
    lc4_pipe_pkg::wb_t wb;
    logic [2:0]        sub;
    logic [15:0]       rs;
    logic [15:0]       rt;
    logic [15:0]       res;

    sub = insn[5:3];
    rs  = regs[insn[8:6]];
    rt  = regs[insn[2:0]];
    res = '0;
    wb  = '{pc: pc, insn: insn, stall: lc4_pipe_pkg::STALL_NONE, default: '0};
    case (insn[15:12])
        lc4_isa_pkg::OP_ARITH: begin
            wb.rd_we = sub[2] || sub != lc4_isa_pkg::ARITH_DIV;
            if (sub[2]) res = rs + {{11{insn[4]}}, insn[4:0]};
            else if (sub == lc4_isa_pkg::ARITH_MUL) res = rs * rt;
            else if (sub == lc4_isa_pkg::ARITH_SUB) res = rs - rt;
            else res = rs + rt;
        end
        lc4_isa_pkg::OP_LOGIC: begin
            wb.rd_we = 1'b1;
            if (sub[2]) res = rs & {{11{insn[4]}}, insn[4:0]};
            else if (sub == lc4_isa_pkg::LOGIC_AND) res = rs & rt;
            else if (sub == lc4_isa_pkg::LOGIC_NOT) res = ~rs;
            else if (sub == lc4_isa_pkg::LOGIC_OR) res = rs | rt;
            else res = rs ^ rt;
        end
        lc4_isa_pkg::OP_CONST: begin
            wb.rd_we = 1'b1;
            res      = {{7{insn[8]}}, insn[8:0]};
        end
        lc4_isa_pkg::OP_LDR: begin
            wb.rd_we     = 1'b1;
            wb.dmem_addr = rs + {{10{insn[5]}}, insn[5:0]};
            wb.dmem_data = dmem[wb.dmem_addr[7:0]];
            res          = wb.dmem_data;
        end
        lc4_isa_pkg::OP_STR: begin
            wb.dmem_we   = 1'b1;
            wb.dmem_addr = rs + {{10{insn[5]}}, insn[5:0]};
            wb.dmem_data = regs[insn[11:9]];
            dmem[wb.dmem_addr[7:0]] = wb.dmem_data;
        end
        default: begin
            res = '0;
        end
    endcase
    if (wb.rd_we) begin
        wb.rd     = insn[11:9];
        wb.wdata  = res;
        wb.nzp_we = 1'b1;
        wb.nzp    = lc4_isa_pkg::nzp_of(res);
        regs[insn[11:9]] = res;
        nzp = wb.nzp;
    end
    if (insn[15:12] == lc4_isa_pkg::OP_BR && |(nzp & insn[11:9])) begin
        pc = pc + 16'd1 + {{7{insn[8]}}, insn[8:0]};
    end else begin
        pc = pc + 16'd1;
    end
    return wb;
endfunction

`endif

// ==== tests/tb_lc4_core.sv ====
// testbench for the LC4 pipeline: clock, reset, memory models, program
// generation, reference trace and the trace compare process
`timescale 1ns/1ps

module tb_lc4_core;

    localparam logic [15:0] RESET_PC       = 16'h8200;
    localparam int          PROG_LEN       = 200;
    localparam logic [31:0] SEED           = 32'hcf23_a655;
    localparam int          RESET_CYCLES   = 16;
    localparam int          RETIRE_TIMEOUT = 12;
    localparam int          MAX_REF_STEPS  = 1000;
    localparam int          CLK_HALF       = 2;
    localparam int          DRIVE_DELAY    = 1;

    logic               gwe;
    logic               i_rst;
    logic [15:0]        o_imem_addr;
    lc4_isa_pkg::insn_t i_imem_insn;
    logic [15:0]        o_dmem_addr;
    logic               o_dmem_we;
    logic [15:0]        o_dmem_wdata;
    logic [15:0]        i_dmem_rdata;
    lc4_pipe_pkg::wb_t  o_wb;

    lc4_isa_pkg::insn_t   imem [256];
    logic [15:0]          dmem [256];
    logic [15:0]          ref_regs [8];
    logic [15:0]          ref_dmem [256];
    lc4_pipe_pkg::wb_t    exp_q [$];
    int                   gap_q [$];
    lc4_pipe_pkg::stall_t kind_q [$];
    int                   n_load_stall;
    int                   n_taken;
    int                   n_not_taken;
    logic                 wr_en;
    logic [15:0]          wr_addr;
    logic [15:0]          wr_data;

    `include "lc4_tb_ref.svh"

    lc4_core #(.RESET_PC(RESET_PC)) DUT (
        .gwe         (gwe),
        .i_rst       (i_rst),
        .o_imem_addr (o_imem_addr),
        .i_imem_insn (i_imem_insn),
        .o_dmem_addr (o_dmem_addr),
        .o_dmem_we   (o_dmem_we),
        .o_dmem_wdata(o_dmem_wdata),
        .i_dmem_rdata(i_dmem_rdata),
        .o_wb        (o_wb)
    );

    always #CLK_HALF gwe = ~gwe;

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
            input logic [15:0] exp_val);
        assert (got === exp_val) else begin
            report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h at %0t",
                name, got, exp_val, $time));
        end
    endtask

    task automatic check_bubble(input lc4_pipe_pkg::stall_t kind);
        check_value("o_wb.stall", o_wb.stall, kind);
        check_value("o_wb.rd_we", o_wb.rd_we, '0);
        check_value("o_wb.nzp_we", o_wb.nzp_we, '0);
        check_value("o_wb.dmem_we", o_wb.dmem_we, '0);
    endtask

    task automatic check_record(input lc4_pipe_pkg::wb_t got, input lc4_pipe_pkg::wb_t ex);
        check_value("o_wb.pc", got.pc, ex.pc);
        check_value("o_wb.insn", got.insn, ex.insn);
        check_value("o_wb.stall", got.stall, ex.stall);
        check_value("o_wb.rd_we", got.rd_we, ex.rd_we);
        check_value("o_wb.rd", got.rd, ex.rd);
        check_value("o_wb.wdata", got.wdata, ex.wdata);
        check_value("o_wb.nzp_we", got.nzp_we, ex.nzp_we);
        check_value("o_wb.nzp", got.nzp, ex.nzp);
        check_value("o_wb.dmem_we", got.dmem_we, ex.dmem_we);
        check_value("o_wb.dmem_addr", got.dmem_addr, ex.dmem_addr);
        check_value("o_wb.dmem_data", got.dmem_data, ex.dmem_data);
    endtask

    // source registers that the hazard rule looks at, store data excluded
    function automatic bit reads_reg(input lc4_isa_pkg::insn_t insn,
            input lc4_isa_pkg::reg_sel_t r);
        logic [3:0] op;
        logic [2:0] sub;
        logic       rt_used;

        op  = insn[15:12];
        sub = insn[5:3];
        if (op == lc4_isa_pkg::OP_LDR || op == lc4_isa_pkg::OP_STR) begin
            return insn[8:6] == r;
        end
        if (op != lc4_isa_pkg::OP_ARITH && op != lc4_isa_pkg::OP_LOGIC) begin
            return 1'b0;
        end
        rt_used = !sub[2] && !(op == lc4_isa_pkg::OP_LOGIC && sub == lc4_isa_pkg::LOGIC_NOT);
        return insn[8:6] == r || (rt_used && insn[2:0] == r);
    endfunction

    function automatic bit load_use(input lc4_isa_pkg::insn_t prev,
            input lc4_isa_pkg::insn_t cur);
        return prev[15:12] == lc4_isa_pkg::OP_LDR
            && (cur[15:12] == lc4_isa_pkg::OP_BR || reads_reg(cur, prev[11:9]));
    endfunction

    // r7 stays the data base register, only CONST rewrites it
    function automatic lc4_isa_pkg::insn_t random_insn(input int idx);
        int                    kind;
        int                    room;
        logic [3:0]            op;
        logic [2:0]            sub;
        lc4_isa_pkg::reg_sel_t rd;
        lc4_isa_pkg::reg_sel_t rs;
        lc4_isa_pkg::reg_sel_t rt;

        kind = $urandom % 16;
        rd   = 3'($urandom % 7);
        rs   = 3'($urandom % 8);
        rt   = 3'($urandom % 8);
        room = PROG_LEN - 2 - idx;
        if (kind < 2) begin
            return enc_mem(lc4_isa_pkg::OP_LDR, rd, 3'd7, 6'($urandom));
        end else if (kind < 4) begin
            return enc_mem(lc4_isa_pkg::OP_STR, rt, 3'd7, 6'($urandom));
        end else if (kind == 4) begin
            return enc_const(3'd7, 9'(32 + $urandom % 160));
        end else if (kind < 7) begin
            return enc_const(rd, 9'($urandom));
        end else if (kind < 9) begin
            // forward only, never past the closing self-branch
            return enc_br(3'($urandom % 7 + 1), 9'($urandom % ((room < 6 ? room : 6) + 1)));
        end
        op  = ($urandom % 2) ? lc4_isa_pkg::OP_ARITH : lc4_isa_pkg::OP_LOGIC;
        sub = 3'($urandom);
        if (op == lc4_isa_pkg::OP_ARITH && sub == lc4_isa_pkg::ARITH_DIV) begin
            sub = lc4_isa_pkg::ARITH_ADD;
        end
        if (sub[2]) begin
            return enc_imm5(op, rd, rs, 5'($urandom));
        end
        return enc_rrr(op, sub, rd, rs, rt);
    endfunction

    task automatic build_program();
        for (int i = 0; i < 256; i++) begin
            imem[i]     = enc_br(3'b000, 9'(i));
            dmem[i]     = {~8'(i), 8'(i)};
            ref_dmem[i] = dmem[i];
        end
        // directed opening: bypass chains, store and load, stalls, branches
        imem[0]  = enc_const(3'd7, 9'h040);
        imem[1]  = enc_const(3'd1, 9'd5);
        imem[2]  = enc_rrr(lc4_isa_pkg::OP_ARITH, lc4_isa_pkg::ARITH_ADD, 3'd2, 3'd1, 3'd1);
        imem[3]  = enc_rrr(lc4_isa_pkg::OP_ARITH, lc4_isa_pkg::ARITH_MUL, 3'd3, 3'd2, 3'd1);
        imem[4]  = enc_rrr(lc4_isa_pkg::OP_ARITH, lc4_isa_pkg::ARITH_SUB, 3'd4, 3'd3, 3'd2);
        imem[5]  = enc_mem(lc4_isa_pkg::OP_STR, 3'd4, 3'd7, 6'd0);
        imem[6]  = enc_mem(lc4_isa_pkg::OP_LDR, 3'd5, 3'd7, 6'd0);
        imem[7]  = enc_rrr(lc4_isa_pkg::OP_ARITH, lc4_isa_pkg::ARITH_ADD, 3'd6, 3'd5, 3'd5);
        imem[8]  = enc_mem(lc4_isa_pkg::OP_LDR, 3'd1, 3'd7, 6'd1);
        imem[9]  = enc_br(3'b111, 9'd1);
        imem[10] = enc_const(3'd0, 9'h0aa);
        imem[11] = enc_const(3'd2, 9'h1f0);
        imem[12] = enc_br(3'b001, 9'd2);
        imem[13] = enc_imm5(lc4_isa_pkg::OP_ARITH, 3'd3, 3'd2, 5'h03);
        imem[14] = enc_mem(lc4_isa_pkg::OP_LDR, 3'd3, 3'd7, 6'd2);
        imem[15] = enc_mem(lc4_isa_pkg::OP_STR, 3'd3, 3'd7, 6'd3);
        for (int i = 16; i < PROG_LEN - 1; i++) begin
            imem[i] = random_insn(i);
        end
        imem[PROG_LEN-1] = enc_br(3'b111, 9'h1ff);
    endtask

    // expected retirement order with the bubbles that precede each record
    task automatic build_expected();
        lc4_isa_pkg::insn_t insn;
        lc4_isa_pkg::insn_t prev_insn;
        lc4_pipe_pkg::wb_t  rec;
        lc4_isa_pkg::nzp_t  nzp;
        logic [15:0]        pc;
        logic [15:0]        prev_pc;
        logic [15:0]        offs;
        logic               prev_taken;

        pc         = RESET_PC;
        nzp        = '0;
        prev_insn  = '0;
        prev_taken = 1'b0;
        for (int r = 0; r < 8; r++) begin
            ref_regs[r] = '0;
        end
        for (int step = 0; step < MAX_REF_STEPS; step++) begin
            offs    = pc - RESET_PC;
            insn    = imem[offs[7:0]];
            prev_pc = pc;
            rec     = ref_step(insn, pc, ref_regs, nzp, ref_dmem);
            exp_q.push_back(rec);
            if (step > 0 && prev_taken) begin
                gap_q.push_back(2);
                kind_q.push_back(lc4_pipe_pkg::STALL_FLUSH);
            end else if (step > 0 && load_use(prev_insn, insn)) begin
                gap_q.push_back(1);
                kind_q.push_back(lc4_pipe_pkg::STALL_LOAD);
                n_load_stall++;
            end else begin
                gap_q.push_back(0);
                kind_q.push_back(lc4_pipe_pkg::STALL_NONE);
            end
            prev_taken = insn[15:12] == lc4_isa_pkg::OP_BR && |(nzp & insn[11:9]);
            if (insn[15:12] == lc4_isa_pkg::OP_BR) begin
                if (prev_taken) n_taken++;
                else n_not_taken++;
            end
            prev_insn = insn;
            if (pc == prev_pc) begin
                return;
            end
        end
        report_failure("reference model never reached the closing self-branch");
    endtask

    initial begin : stimulus
        gwe          = 1'b0;
        i_rst        = 1'b1;
        i_imem_insn  = '0;
        i_dmem_rdata = '0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        n_load_stall = 0;
        n_taken      = 0;
        n_not_taken  = 0;
        void'($urandom(SEED));
        build_program();
        build_expected();
        repeat (RESET_CYCLES) @(posedge gwe);
        #DRIVE_DELAY;
        i_rst = 1'b0;
    end

    // store seen during the cycle lands before the next read
    always @(negedge gwe) begin : store_capture
        wr_en   = (o_dmem_we === 1'b1) && (i_rst === 1'b0);
        wr_addr = o_dmem_addr;
        wr_data = o_dmem_wdata;
    end

    always @(posedge gwe) begin : memory_model
        logic [15:0] offs;
        #DRIVE_DELAY;
        if (wr_en) begin
            dmem[wr_addr[7:0]] = wr_data;
        end
        offs         = o_imem_addr - RESET_PC;
        i_imem_insn  = (offs < 16'd256) ? imem[offs[7:0]] : '0;
        i_dmem_rdata = dmem[o_dmem_addr[7:0]];
    end

    initial begin : compare
        int n;
        @(negedge gwe);
        for (n = 0; i_rst === 1'b1; n++) begin
            if (n > RESET_CYCLES) begin
                report_failure("reset stayed asserted longer than expected");
            end
            check_value("o_dmem_we", o_dmem_we, '0);
            check_value("o_imem_addr", o_imem_addr, RESET_PC);
            check_bubble(lc4_pipe_pkg::STALL_FLUSH);
            @(negedge gwe);
        end
        check_value("o_imem_addr", o_imem_addr, RESET_PC);
        for (n = 0; o_wb.stall != lc4_pipe_pkg::STALL_NONE; n++) begin
            if (n >= RETIRE_TIMEOUT) begin
                report_failure("timed out waiting for the first instruction to retire");
            end
            check_bubble(lc4_pipe_pkg::STALL_FLUSH);
            @(negedge gwe);
        end
        for (int k = 0; k < exp_q.size(); k++) begin
            for (int b = 0; b < gap_q[k]; b++) begin
                check_bubble(kind_q[k]);
                @(negedge gwe);
            end
            check_record(o_wb, exp_q[k]);
            @(negedge gwe);
        end
        if (n_load_stall == 0 || n_taken == 0 || n_not_taken == 0) begin
            report_failure("program missed load stalls or one of the branch outcomes");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== lc4_core.f ====
src/lc4_isa_pkg.sv
src/lc4_pipe_pkg.sv
src/lc4_fetch_stage.sv
src/lc4_decode_stage.sv
src/lc4_execute_stage.sv
src/lc4_memory_stage.sv
src/lc4_core.sv
+incdir+include
tests/tb_lc4_core.sv
